// File: rtl/icache_pkg.sv
package icache_pkg;

    // -------------------------------------------------------------------------
    // Widths shared by the fetch port, the memory port and the counters
    // -------------------------------------------------------------------------

    // Byte address on both the fetch and the memory side
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    typedef logic [31:0] count_t;

    // Byte-in-word bits of an address
    localparam int OFFSET_WIDTH = 2;

    // Top byte of every cacheable address
    localparam logic [7:0] CACHEABLE_REGION = 8'ha0;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_RESP,
        REFILL_REQ,
        REFILL_DATA,
        REFILL_RESP,
        BYPASS_REQ,
        BYPASS_DATA
    } cache_state_t;

endpackage

// File: rtl/fetch_addr_decode.sv
module fetch_addr_decode import icache_pkg::*; #(
    parameter int LINE_WORDS_LOG2 = 2,
    parameter int INDEX_WIDTH     = 3,
    localparam int TAG_WIDTH      = $bits(addr_t) - OFFSET_WIDTH - LINE_WORDS_LOG2
                                    - INDEX_WIDTH
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       fetch_ar_valid,
    input  logic                       fetch_ar_ready,
    input  addr_t                      fetch_ar_addr,
    output addr_t                      req_addr,
    output logic [TAG_WIDTH-1:0]       req_tag,
    output logic [INDEX_WIDTH-1:0]     req_index,
    output logic [LINE_WORDS_LOG2-1:0] req_word,
    output logic                       req_cacheable
);

    localparam int INDEX_LSB = OFFSET_WIDTH + LINE_WORDS_LOG2;

    // Address is held from one fetch handshake to the next
    always_ff @(posedge clock) begin
        if (fetch_ar_valid && fetch_ar_ready) begin
            req_addr <= fetch_ar_addr;
        end
    end

    // Field split of the held address
    assign req_word  = req_addr[OFFSET_WIDTH +: LINE_WORDS_LOG2];
    assign req_index = req_addr[INDEX_LSB +: INDEX_WIDTH];
    assign req_tag   = req_addr[$bits(addr_t)-1 -: TAG_WIDTH];

    // Only the a0 region goes through the cache
    assign req_cacheable = (req_addr[$bits(addr_t)-1 -: 8] == CACHEABLE_REGION);

    // Fetch unit must not change the address while it waits for ready
    assert property (@(posedge clock) disable iff (reset)
        fetch_ar_valid && !fetch_ar_ready |=> $stable(fetch_ar_addr))
        else $error("fetch_ar_addr changed while waiting for fetch_ar_ready");

endmodule

// File: rtl/icache_ctrl.sv
module icache_ctrl import icache_pkg::*; #(
    parameter int LINE_WORDS_LOG2 = 2,
    parameter int INDEX_WIDTH     = 3,
    localparam int TAG_WIDTH      = $bits(addr_t) - OFFSET_WIDTH - LINE_WORDS_LOG2
                                    - INDEX_WIDTH
) (
    input  logic                       clock,
    input  logic                       reset,
    input  addr_t                      req_addr,
    input  logic [TAG_WIDTH-1:0]       req_tag,
    input  logic [INDEX_WIDTH-1:0]     req_index,
    input  logic                       req_cacheable,
    input  logic                       fetch_ar_valid,
    input  logic                       resp_done,
    input  logic                       mem_ar_ready,
    input  logic                       mem_r_valid,
    input  logic                       mem_r_last,
    output logic                       fetch_ar_ready,
    output logic                       mem_ar_valid,
    output addr_t                      mem_ar_addr,
    output logic [7:0]                 mem_ar_len,
    output logic                       fill_en,
    output logic [LINE_WORDS_LOG2-1:0] fill_word,
    output logic                       resp_load,
    output logic                       resp_from_mem,
    output count_t                     hit_count,
    output count_t                     miss_count
);

    localparam int LINES              = 1 << INDEX_WIDTH;
    localparam int LINE_OFFSET        = LINE_WORDS_LOG2 + OFFSET_WIDTH;
    localparam logic [7:0] REFILL_LEN = 8'((1 << LINE_WORDS_LOG2) - 1);

    cache_state_t         state;
    logic [TAG_WIDTH-1:0] tag_mem [LINES];
    logic [LINES-1:0]     valid_bits;
    logic                 lookup_hit;
    logic                 lookup_miss;

    // ------------------------------------------------------------------------
    // Tag compare
    // ------------------------------------------------------------------------
    assign lookup_hit  = (state == LOOKUP) && req_cacheable && valid_bits[req_index]
                         && (tag_mem[req_index] == req_tag);
    assign lookup_miss = (state == LOOKUP) && req_cacheable && !lookup_hit;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (fetch_ar_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    // Bypass request already goes out in this cycle
                    if (!req_cacheable) begin
                        state <= mem_ar_ready ? BYPASS_DATA : BYPASS_REQ;
                    end else if (lookup_hit) begin
                        state <= HIT_RESP;
                    end else begin
                        state <= REFILL_REQ;
                    end
                end
                REFILL_REQ: begin
                    if (mem_ar_ready) begin
                        state <= REFILL_DATA;
                    end
                end
                REFILL_DATA: begin
                    if (mem_r_valid && mem_r_last) begin
                        state <= REFILL_RESP;
                    end
                end
                BYPASS_REQ: begin
                    if (mem_ar_ready) begin
                        state <= BYPASS_DATA;
                    end
                end
                // Response waits share one exit, and in BYPASS_DATA
                // resp_done cannot come before the beat has been loaded
                HIT_RESP, REFILL_RESP, BYPASS_DATA: begin
                    if (resp_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Refill beat counter
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fill_word <= '0;
        end else if (state == LOOKUP) begin
            fill_word <= '0;
        end else if (fill_en) begin
            fill_word <= fill_word + 1'b1;
        end
    end

    // New tag is claimed as soon as the miss is seen
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (lookup_miss) begin
            valid_bits[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_miss) begin
            tag_mem[req_index] <= req_tag;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (lookup_hit) begin
                hit_count <= hit_count + 1'b1;
            end
            if (lookup_miss) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Port outputs
    // ------------------------------------------------------------------------
    assign fetch_ar_ready = (state == IDLE);
    assign mem_ar_valid   = (state == REFILL_REQ) || (state == BYPASS_REQ)
                            || ((state == LOOKUP) && !req_cacheable);
    assign mem_ar_addr    = req_cacheable
                            ? {req_addr[$bits(addr_t)-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}}
                            : req_addr;
    assign mem_ar_len     = req_cacheable ? REFILL_LEN : 8'd0;
    assign fill_en        = (state == REFILL_DATA) && mem_r_valid;
    assign resp_from_mem  = (state == BYPASS_DATA);
    assign resp_load      = lookup_hit || (fill_en && mem_r_last)
                            || ((state == BYPASS_DATA) && mem_r_valid);

    assert property (@(posedge clock) disable iff (reset)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_addr))
        else $error("mem_ar_valid dropped before mem_ar_ready");

    // Burst must not end short of a full line
    assert property (@(posedge clock) disable iff (reset)
        fill_en && mem_r_last |-> &fill_word)
        else $error("mem_r_last before the last refill beat");

endmodule

// File: rtl/icache_data_array.sv
module icache_data_array import icache_pkg::*; #(
    parameter int LINE_WORDS_LOG2 = 2,
    parameter int INDEX_WIDTH     = 3
) (
    input  logic                       clock,
    input  logic [INDEX_WIDTH-1:0]     req_index,
    input  logic [LINE_WORDS_LOG2-1:0] req_word,
    input  logic                       fill_en,
    input  logic [LINE_WORDS_LOG2-1:0] fill_word,
    input  word_t                      mem_r_data,
    output word_t                      line_word
);

    localparam int ADDR_WIDTH = INDEX_WIDTH + LINE_WORDS_LOG2;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    word_t                 lines [DEPTH];
    logic [ADDR_WIDTH-1:0] fill_addr;
    logic [ADDR_WIDTH-1:0] read_addr;

    // One word per line slot, line index in the upper bits
    assign fill_addr = {req_index, fill_word};
    assign read_addr = {req_index, req_word};

    always_ff @(posedge clock) begin
        if (fill_en) begin
            lines[fill_addr] <= mem_r_data;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // The last refill beat is read in the same cycle it is written,
    // so a beat for the requested word is forwarded past the array
    always_comb begin
        if (fill_en && (fill_word == req_word)) begin
            line_word = mem_r_data;
        end else begin
            line_word = lines[read_addr];
        end
    end

endmodule

// File: rtl/fetch_resp_sel.sv
module fetch_resp_sel import icache_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  resp_load,
    input  logic  resp_from_mem,
    input  word_t line_word,
    input  word_t mem_r_data,
    input  logic  fetch_r_ready,
    output logic  fetch_r_valid,
    output word_t fetch_r_data,
    output logic  resp_done
);

    assign resp_done = fetch_r_valid && fetch_r_ready;

    // Response pending flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_r_valid <= 1'b0;
        end else if (resp_load) begin
            fetch_r_valid <= 1'b1;
        end else if (resp_done) begin
            fetch_r_valid <= 1'b0;
        end
    end

    // Bypass beat or cached word, held until accepted
    always_ff @(posedge clock) begin
        if (resp_load) begin
            fetch_r_data <= resp_from_mem ? mem_r_data : line_word;
        end
    end

    // ------------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------------

    // Controller may only load once the previous response has gone
    assert property (@(posedge clock) disable iff (reset)
        resp_load |-> !fetch_r_valid)
        else $error("resp_load while a fetch response is pending");

endmodule

// File: rtl/icache_top.sv
module icache_top import icache_pkg::*; #(
    parameter int LINE_WORDS_LOG2 = 2,
    parameter int INDEX_WIDTH     = 3
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetch_ar_valid,
    output logic       fetch_ar_ready,
    input  addr_t      fetch_ar_addr,
    output logic       fetch_r_valid,
    input  logic       fetch_r_ready,
    output word_t      fetch_r_data,
    output logic       mem_ar_valid,
    input  logic       mem_ar_ready,
    output addr_t      mem_ar_addr,
    output logic [7:0] mem_ar_len,
    input  logic       mem_r_valid,
    input  word_t      mem_r_data,
    input  logic       mem_r_last,
    output count_t     hit_count,
    output count_t     miss_count
);

    localparam int TAG_WIDTH = $bits(addr_t) - OFFSET_WIDTH - LINE_WORDS_LOG2 - INDEX_WIDTH;

    addr_t                      req_addr;
    logic [TAG_WIDTH-1:0]       req_tag;
    logic [INDEX_WIDTH-1:0]     req_index;
    logic [LINE_WORDS_LOG2-1:0] req_word;
    logic                       req_cacheable;
    logic                       fill_en;
    logic [LINE_WORDS_LOG2-1:0] fill_word;
    logic                       resp_load;
    logic                       resp_from_mem;
    logic                       resp_done;
    word_t                      line_word;

    // Decode
    fetch_addr_decode #(
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2),
        .INDEX_WIDTH     (INDEX_WIDTH)
    ) decode0 (
        .clock          (clock),
        .reset          (reset),
        .fetch_ar_valid (fetch_ar_valid),
        .fetch_ar_ready (fetch_ar_ready),
        .fetch_ar_addr  (fetch_ar_addr),
        .req_addr       (req_addr),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .req_word       (req_word),
        .req_cacheable  (req_cacheable)
    );

    // Lookup, refill and bypass control
    icache_ctrl #(
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2),
        .INDEX_WIDTH     (INDEX_WIDTH)
    ) ctrl0 (
        .clock          (clock),
        .reset          (reset),
        .req_addr       (req_addr),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .req_cacheable  (req_cacheable),
        .fetch_ar_valid (fetch_ar_valid),
        .resp_done      (resp_done),
        .mem_ar_ready   (mem_ar_ready),
        .mem_r_valid    (mem_r_valid),
        .mem_r_last     (mem_r_last),
        .fetch_ar_ready (fetch_ar_ready),
        .mem_ar_valid   (mem_ar_valid),
        .mem_ar_addr    (mem_ar_addr),
        .mem_ar_len     (mem_ar_len),
        .fill_en        (fill_en),
        .fill_word      (fill_word),
        .resp_load      (resp_load),
        .resp_from_mem  (resp_from_mem),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    icache_data_array #(
        .LINE_WORDS_LOG2 (LINE_WORDS_LOG2),
        .INDEX_WIDTH     (INDEX_WIDTH)
    ) data0 (
        .clock      (clock),
        .req_index  (req_index),
        .req_word   (req_word),
        .fill_en    (fill_en),
        .fill_word  (fill_word),
        .mem_r_data (mem_r_data),
        .line_word  (line_word)
    );

    // Fetch response
    fetch_resp_sel resp0 (
        .clock         (clock),
        .reset         (reset),
        .resp_load     (resp_load),
        .resp_from_mem (resp_from_mem),
        .line_word     (line_word),
        .mem_r_data    (mem_r_data),
        .fetch_r_ready (fetch_r_ready),
        .fetch_r_valid (fetch_r_valid),
        .fetch_r_data  (fetch_r_data),
        .resp_done     (resp_done)
    );

endmodule

// File: test/icache_mem_model.sv
module icache_mem_model import icache_pkg::*; (
    input  logic       clock,
    input  logic       mem_ar_valid,
    output logic       mem_ar_ready,
    input  addr_t      mem_ar_addr,
    input  logic [7:0] mem_ar_len,
    output logic       mem_r_valid,
    output word_t      mem_r_data,
    output logic       mem_r_last
);

    // Every word address answers with its own address xor a fixed pattern
    function automatic word_t word_at(input addr_t addr);
        return addr ^ 32'h5a5a5a5a;
    endfunction

    initial begin
        addr_t      base;
        logic [7:0] len;
        int         stall;
        int         beat;
        mem_ar_ready = 1'b0;
        mem_r_valid  = 1'b0;
        mem_r_data   = '0;
        mem_r_last   = 1'b0;
        forever begin
            @(negedge clock);
            if (mem_ar_valid === 1'b1) begin
                base  = mem_ar_addr;
                len   = mem_ar_len;
                // Random address stall before the request is taken
                stall = $urandom_range(3, 0);
                repeat (stall) @(posedge clock);
                @(posedge clock);
                #1;
                mem_ar_ready = 1'b1;
                @(posedge clock);
                #1;
                mem_ar_ready = 1'b0;
                // Beats back to back, ascending word order
                for (beat = 0; beat <= int'(len); beat++) begin
                    mem_r_valid = 1'b1;
                    mem_r_data  = word_at(base + addr_t'(4 * beat));
                    mem_r_last  = (beat == int'(len));
                    @(posedge clock);
                    #1;
                end
                mem_r_valid = 1'b0;
                mem_r_last  = 1'b0;
            end
        end
    end

endmodule

// File: test/icache_tb.sv
module icache_tb import icache_pkg::*; ();

    localparam int RESET_CYCLES   = 3;
    localparam int CYCLES_PER_VEC = 200;
    // 4 words of 4 bytes per line
    localparam int LINE_WORDS     = 4;
    localparam int LINE_BYTES     = 4 * LINE_WORDS;

    logic       clock;
    logic       reset;
    logic       fetch_ar_valid;
    logic       fetch_ar_ready;
    addr_t      fetch_ar_addr;
    logic       fetch_r_valid;
    logic       fetch_r_ready;
    word_t      fetch_r_data;
    logic       mem_ar_valid;
    logic       mem_ar_ready;
    addr_t      mem_ar_addr;
    logic [7:0] mem_ar_len;
    logic       mem_r_valid;
    word_t      mem_r_data;
    logic       mem_r_last;
    count_t     hit_count;
    count_t     miss_count;

    addr_t      vec_addr [$];
    word_t      vec_data [$];
    logic       vec_hit  [$];
    bit         vectors_loaded;
    int         cycle;
    int         req_count;
    addr_t      req_addr;
    logic [7:0] req_len;
    count_t     exp_hits;
    count_t     exp_misses;

    icache_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .fetch_ar_valid (fetch_ar_valid),
        .fetch_ar_ready (fetch_ar_ready),
        .fetch_ar_addr  (fetch_ar_addr),
        .fetch_r_valid  (fetch_r_valid),
        .fetch_r_ready  (fetch_r_ready),
        .fetch_r_data   (fetch_r_data),
        .mem_ar_valid   (mem_ar_valid),
        .mem_ar_ready   (mem_ar_ready),
        .mem_ar_addr    (mem_ar_addr),
        .mem_ar_len     (mem_ar_len),
        .mem_r_valid    (mem_r_valid),
        .mem_r_data     (mem_r_data),
        .mem_r_last     (mem_r_last),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    icache_mem_model mem0 (
        .clock        (clock),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_ar_addr  (mem_ar_addr),
        .mem_ar_len   (mem_ar_len),
        .mem_r_valid  (mem_r_valid),
        .mem_r_data   (mem_r_data),
        .mem_r_last   (mem_r_last)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Memory request monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (mem_ar_valid && mem_ar_ready) begin
            req_count <= req_count + 1;
            req_addr  <= mem_ar_addr;
            req_len   <= mem_ar_len;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        addr_t       addr;
        word_t       data;
        logic [31:0] hit;
        fd = $fopen("test/icache_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/icache_vectors.txt");
        end
        // Comment lines do not parse as three hex fields
        while ($fgets(line, fd) > 0) begin
            fields = $sscanf(line, "%h %h %h", addr, data, hit);
            if (fields == 3) begin
                vec_addr.push_back(addr);
                vec_data.push_back(data);
                vec_hit.push_back(hit[0]);
            end
        end
        $fclose(fd);
        if (vec_addr.size() == 0) begin
            abort_run("The vectors file holds no fetches");
        end
        vectors_loaded = 1'b1;
    endtask

    // Number of cacheable vectors whose hit flag equals the given value
    function automatic count_t count_cacheable(input logic hit);
        count_t total;
        total = '0;
        foreach (vec_addr[i]) begin
            if ((vec_addr[i][31:24] == 8'ha0) && (vec_hit[i] == hit)) begin
                total++;
            end
        end
        return total;
    endfunction

    // One fetch from address handshake to accepted response
    task automatic run_fetch(input addr_t addr, input word_t exp_data, input logic exp_hit);
        int    hs_cycle;
        int    latency;
        int    stall;
        int    reqs_before;
        bit    taken;
        bit    seen;
        bit    done;
        bit    cacheable;
        word_t first_data;
        stall       = $urandom_range(2, 0);
        reqs_before = req_count;
        cacheable   = (addr[31:24] == 8'ha0);
        taken       = 1'b0;
        seen        = 1'b0;
        done        = 1'b0;
        fetch_ar_valid = 1'b1;
        fetch_ar_addr  = addr;
        while (!taken) begin
            @(negedge clock);
            hs_cycle = cycle;
            taken    = fetch_ar_ready;
            @(posedge clock);
            #1;
        end
        fetch_ar_valid = 1'b0;

        fetch_r_ready = (stall == 0);
        while (!done) begin
            @(negedge clock);
            if (fetch_r_valid) begin
                if (!seen) begin
                    seen       = 1'b1;
                    first_data = fetch_r_data;
                    latency    = cycle - hs_cycle;
                end
                check("fetch_r_data", fetch_r_data, first_data);
                check("fetch_ar_ready", 32'(fetch_ar_ready), 32'd0);
                done = fetch_r_ready;
            end
            @(posedge clock);
            #1;
            if (seen && !done && stall > 0) begin
                stall--;
                fetch_r_ready = (stall == 0);
            end
        end
        fetch_r_ready = 1'b0;

        check("fetch_r_data", first_data, exp_data);
        if (!cacheable) begin
            check("memory request count", req_count, reqs_before + 1);
            check("mem_ar_addr", req_addr, addr);
            check("mem_ar_len", 32'(req_len), 32'd0);
        end else if (exp_hit) begin
            exp_hits++;
            check("hit latency", latency, 2);
            check("memory request count", req_count, reqs_before);
        end else begin
            exp_misses++;
            check("memory request count", req_count, reqs_before + 1);
            check("mem_ar_addr", req_addr, addr & ~addr_t'(LINE_BYTES - 1));
            check("mem_ar_len", 32'(req_len), 32'(LINE_WORDS - 1));
        end
        check("hit_count", hit_count, exp_hits);
        check("miss_count", miss_count, exp_misses);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(89));
        reset          = 1'b1;
        fetch_ar_valid = 1'b0;
        fetch_ar_addr  = '0;
        fetch_r_ready  = 1'b0;
        exp_hits       = '0;
        exp_misses     = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        @(negedge clock);
        check("fetch_ar_ready", 32'(fetch_ar_ready), 32'd1);
        check("fetch_r_valid", 32'(fetch_r_valid), 32'd0);
        check("mem_ar_valid", 32'(mem_ar_valid), 32'd0);
        check("hit_count", hit_count, 32'd0);
        check("miss_count", miss_count, 32'd0);
        @(posedge clock);
        #1;

        foreach (vec_addr[i]) begin
            run_fetch(vec_addr[i], vec_data[i], vec_hit[i]);
        end

        // Totals over all cacheable vectors, after an idle cycle
        @(negedge clock);
        check("hit_count", hit_count, count_cacheable(1'b1));
        check("miss_count", miss_count, count_cacheable(1'b0));
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (vectors_loaded);
        repeat (RESET_CYCLES + CYCLES_PER_VEC * vec_addr.size()) @(posedge clock);
        abort_run("Run timed out before all fetches completed");
    end

endmodule

// File: icache_sub.f
rtl/icache_pkg.sv
rtl/fetch_addr_decode.sv
rtl/icache_ctrl.sv
rtl/icache_data_array.sv
rtl/fetch_resp_sel.sv
rtl/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

// File: Makefile
.PHONY: run clean

run: obj_dir/Vicache_tb
	@out=$$(./obj_dir/Vicache_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

obj_dir/Vicache_tb: icache_sub.f $(wildcard rtl/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
		-f icache_sub.f -o Vicache_tb

clean:
	rm -rf obj_dir

// File: test/icache_vectors.txt
# address   expected data   expected hit (1 hit, 0 miss or bypass)
# data follows the memory rule: address xor 5a5a5a5a
a0000000 fa5a5a5a 0
a0000004 fa5a5a5e 1
a000000c fa5a5a56 1
a0000008 fa5a5a52 1
00001000 5a5a4a5a 0
a0000010 fa5a5a4a 0
a0000080 fa5a5ada 0
a0000084 fa5a5ade 1
a0000000 fa5a5a5a 0
a000001c fa5a5a46 1
12345678 486e0c22 0
a00000f4 fa5a5aae 0
a00000f0 fa5a5aaa 1
a0000004 fa5a5a5e 1
b0000040 ea5a5a1a 0
a0001000 fa5a4a5a 0
a0000000 fa5a5a5a 0
a0000014 fa5a5a4e 1
a0001008 fa5a4a52 0
a000100c fa5a4a56 1
